/* flist.f */
+incdir+test
hdl/osPkg.sv
hdl/tsRuleMatcher.sv
hdl/tsHistory.sv
hdl/runTracker.sv
hdl/osChecker.sv
test/osCheckerTb.sv

/* hdl/osChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module osChecker #(
    parameter bit isUpstream = 1'b0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid,
    input  osPkg::trainingSet_t   orderedSet,
    input  osPkg::ltssmSubstate_t substate,
    input  logic [7:0]            linkNumber,
    input  logic [7:0]            laneNumber,
    input  logic                  directedSpeedChange,
    output logic                  countUp,
    output logic                  keepCount,
    output logic                  rcvrCfgToIdle,
    output logic [7:0]            rateId,
    output logic [7:0]            linkNumberOut,
    output logic                  upconfigureCapability
);

    osPkg::ruleFlags_t ruleFlags;
    osPkg::sameFlags_t sameFlags;

    tsRuleMatcher #(
        .isUpstream(isUpstream)
    ) matcher0 (
        .set                 (orderedSet),
        .substate            (substate),
        .linkNumber          (linkNumber),
        .laneNumber          (laneNumber),
        .directedSpeedChange (directedSpeedChange),
        .flags               (ruleFlags)
    );

    tsHistory history0 (
        .clk                   (clk),
        .reset                 (reset),
        .valid                 (valid),
        .set                   (orderedSet),
        .same                  (sameFlags),
        .rateId                (rateId),
        .linkNumberOut         (linkNumberOut),
        .upconfigureCapability (upconfigureCapability)
    );

    runTracker tracker0 (
        .clk           (clk),
        .reset         (reset),
        .valid         (valid),
        .substate      (substate),
        .rule          (ruleFlags),
        .same          (sameFlags),
        .countUp       (countUp),
        .keepCount     (keepCount),
        .rcvrCfgToIdle (rcvrCfgToIdle)
    );

endmodule

`default_nettype wire

/* hdl/osPkg.sv */
`default_nettype none

package osPkg;

    // ordered set symbol codes
    localparam logic [7:0] padSym       = 8'hF7;
    localparam logic [7:0] comSym       = 8'hBC;
    localparam logic [7:0] ts1Id        = 8'h4A;
    localparam logic [7:0] ts2Id        = 8'h45;
    localparam logic [7:0] gen3Ts1Start = 8'h1E;  // 128b/130b TS1 block start
    localparam logic [7:0] gen3Ts2Start = 8'h2D;

    // numbering follows the main LTSSM, so unused codes are still listed
    typedef enum logic [4:0] {
        detectQuiet           = 5'd0,
        detectActive          = 5'd1,
        pollingActive         = 5'd2,
        pollingConfiguration  = 5'd3,
        configLinkwidthStart  = 5'd4,
        configLinkwidthAccept = 5'd5,
        configLanenumWait     = 5'd6,
        configLanenumAccept   = 5'd7,
        configComplete        = 5'd8,
        configIdle            = 5'd9,
        l0                    = 5'd10,
        recoveryRcvrLock      = 5'd11,
        recoveryRcvrCfg       = 5'd12,
        recoverySpeed         = 5'd13,
        eqPhase0              = 5'd14,
        eqPhase1              = 5'd15,
        eqPhase2              = 5'd16,
        eqPhase3              = 5'd17,
        recoveryIdle          = 5'd18
    } ltssmSubstate_t;

    // data rate identifier, symbol 4
    typedef struct packed {
        logic       speedChange;    // set bit 39
        logic [3:0] upperBits;
        logic       upconfigure;    // set bit 34
        logic [1:0] lowerBits;
    } rateId_t;

    // symbol 0 sits in the low byte
    typedef struct packed {
        logic [39:0] sym15to11;
        logic [7:0]  idSym;         // symbol 10, TS1 or TS2 identifier
        logic [23:0] sym9to7;
        logic [7:0]  symbol6;
        logic [7:0]  sym5;
        rateId_t     rateId;
        logic [7:0]  sym3;
        logic [7:0]  laneNum;
        logic [7:0]  linkNum;
        logic [7:0]  startSym;
    } trainingSet_t;

    typedef struct packed {
        logic ruleHit;      // set conforms to the substate rule
        logic speedMode;    // RcvrCfg TS2 with speedChange set
        logic anySubstate;  // substate handled by the checker
    } ruleFlags_t;

    // each bit compares the incoming set with the previous valid one
    typedef struct packed {
        logic linkSame;
        logic rateSame;
        logic sym6Same;
        logic modeSame;
    } sameFlags_t;

endpackage

`default_nettype wire

/* hdl/runTracker.sv */
`timescale 1ns/1ps
`default_nettype none

module runTracker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid,
    input  osPkg::ltssmSubstate_t substate,
    input  osPkg::ruleFlags_t     rule,
    input  osPkg::sameFlags_t     same,
    output logic                  countUp,
    output logic                  keepCount,
    output logic                  rcvrCfgToIdle
);

    typedef enum logic [1:0] {
        hunt,
        counting,
        countingIdle    // RcvrCfg run of TS2s without speedChange
    } runState_t;

    runState_t             state;
    runState_t             baseState;
    runState_t             nextState;
    osPkg::ltssmSubstate_t lastSubstate;
    logic                  substateChanged;
    logic                  consistent;
    logic                  nextCountUp;

    assign substateChanged = substate != lastSubstate;

    // a new substate restarts the search
    assign baseState = substateChanged ? hunt : state;

    // extra checks a set needs to continue a run
    always_comb
    begin
        case (substate)
            osPkg::configLinkwidthStart:
                consistent = same.linkSame;
            osPkg::configComplete:
                consistent = same.rateSame;
            osPkg::recoveryRcvrCfg:
                consistent = same.modeSame
                             && (!rule.speedMode || (same.rateSame && same.sym6Same));
            default:
                consistent = 1'b1;
        endcase
    end

    always_comb
    begin
        nextState   = baseState;   // no set, hold the run
        nextCountUp = 1'b0;
        if (valid)
        begin
            if (rule.ruleHit && (baseState == hunt || consistent))
            begin
                nextCountUp = 1'b1;
                if (substate == osPkg::recoveryRcvrCfg && !rule.speedMode)
                    nextState = countingIdle;
                else
                    nextState = counting;
            end
            else
            begin
                nextState = hunt;
            end
        end
    end

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state        <= hunt;
            lastSubstate <= osPkg::detectQuiet;
            countUp      <= 1'b0;
        end
        else
        begin
            state        <= nextState;
            lastSubstate <= substate;
            countUp      <= nextCountUp;
        end
    end

    assign keepCount = state != hunt;

    // drops as soon as the LTSSM leaves RcvrCfg
    assign rcvrCfgToIdle = (state == countingIdle) && !substateChanged;

    // unhandled substates must never start a run
    hitOnlyInKept: assert property (
        @(posedge clk) disable iff (!reset)
        rule.ruleHit |-> rule.anySubstate
    ) else $error("rule hit reported outside a handled substate");

    countUpInRun: assert property (
        @(posedge clk) disable iff (!reset)
        countUp |-> keepCount
    ) else $error("countUp outside a run");

    idleOnlyInRcvrCfg: assert property (
        @(posedge clk) disable iff (!reset)
        rcvrCfgToIdle |-> substate == osPkg::recoveryRcvrCfg
    ) else $error("rcvrCfgToIdle outside Recovery.RcvrCfg");

endmodule

`default_nettype wire

/* hdl/tsHistory.sv */
`timescale 1ns/1ps
`default_nettype none

module tsHistory (
    input  logic                clk,
    input  logic                reset,
    input  logic                valid,
    input  osPkg::trainingSet_t set,
    output osPkg::sameFlags_t   same,
    output logic [7:0]          rateId,
    output logic [7:0]          linkNumberOut,
    output logic                upconfigureCapability
);

    osPkg::trainingSet_t lastSet;

    // partner outputs are zero until the first set arrives
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            lastSet <= '0;
        end
        else if (valid)
        begin
            lastSet <= set;
        end
    end

    // field compares against the previous valid set
    assign same.linkSame = set.linkNum == lastSet.linkNum;
    assign same.rateSame = set.rateId == lastSet.rateId;  // whole byte
    assign same.sym6Same = set.symbol6 == lastSet.symbol6;
    assign same.modeSame = set.rateId.speedChange == lastSet.rateId.speedChange;

    assign rateId                = lastSet.rateId;
    assign linkNumberOut         = lastSet.linkNum;
    assign upconfigureCapability = lastSet.rateId.upconfigure;

endmodule

`default_nettype wire

/* hdl/tsRuleMatcher.sv */
`timescale 1ns/1ps
`default_nettype none

module tsRuleMatcher #(
    parameter bit isUpstream = 1'b0
) (
    input  osPkg::trainingSet_t   set,
    input  osPkg::ltssmSubstate_t substate,
    input  logic [7:0]            linkNumber,
    input  logic [7:0]            laneNumber,
    input  logic                  directedSpeedChange,
    output osPkg::ruleFlags_t     flags
);

    logic ts1Start;
    logic ts2Start;
    logic isTs1;
    logic isTs2;
    logic anyTs;
    logic linkPad;
    logic lanePad;
    logic linkMatch;
    logic laneMatch;
    logic numbersMatch;
    logic allZero;
    logic hit;
    logic kept;

    // gen3 sets carry their own start symbol
    assign ts1Start = (set.startSym == osPkg::comSym) || (set.startSym == osPkg::gen3Ts1Start);
    assign ts2Start = (set.startSym == osPkg::comSym) || (set.startSym == osPkg::gen3Ts2Start);

    assign isTs1 = ts1Start && (set.idSym == osPkg::ts1Id);
    assign isTs2 = ts2Start && (set.idSym == osPkg::ts2Id);
    assign anyTs = isTs1 || isTs2;

    assign linkPad      = set.linkNum == osPkg::padSym;
    assign lanePad      = set.laneNum == osPkg::padSym;
    assign linkMatch    = set.linkNum == linkNumber;
    assign laneMatch    = set.laneNum == laneNumber;
    assign numbersMatch = linkMatch && laneMatch;
    assign allZero      = set == '0;   // logical idle data

    always_comb
    begin
        hit = 1'b0;
        case (substate)
            osPkg::pollingActive:
                hit = anyTs && linkPad && lanePad;
            osPkg::pollingConfiguration:
                hit = isTs2 && linkPad && lanePad;
            osPkg::configLinkwidthStart:
            begin
                // upstream takes whatever link number the downstream port offers
                if (isUpstream)
                    hit = isTs1 && !linkPad && lanePad;
                else
                    hit = isTs1 && linkMatch && lanePad;
            end
            osPkg::configLinkwidthAccept:
                hit = isUpstream && isTs1 && linkMatch && !lanePad;
            osPkg::configLanenumWait,
            osPkg::configLanenumAccept:
            begin
                if (isUpstream)
                    hit = isTs2 && numbersMatch;
                else
                    hit = isTs1 && numbersMatch;
            end
            osPkg::configComplete:
                hit = isTs2 && numbersMatch;
            osPkg::configIdle:
                hit = allZero;
            osPkg::recoveryRcvrLock:
                hit = anyTs && numbersMatch
                      && (set.rateId.speedChange == directedSpeedChange);
            osPkg::recoveryRcvrCfg:
                hit = isTs2 && numbersMatch;
            default:
                hit = 1'b0;
        endcase
    end

    // substates this checker knows, everything else leaves it idle
    assign kept = substate inside {
        osPkg::pollingActive,
        osPkg::pollingConfiguration,
        osPkg::configLinkwidthStart,
        osPkg::configLinkwidthAccept,
        osPkg::configLanenumWait,
        osPkg::configLanenumAccept,
        osPkg::configComplete,
        osPkg::configIdle,
        osPkg::recoveryRcvrLock,
        osPkg::recoveryRcvrCfg
    };

    assign flags.ruleHit     = hit;
    assign flags.speedMode   = (substate == osPkg::recoveryRcvrCfg) && set.rateId.speedChange;
    assign flags.anySubstate = kept;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# builds the osChecker testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module osCheckerTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/VosCheckerTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

/* test/osCheckerTasks.svh */
`ifndef OS_CHECKER_TASKS_SVH
`define OS_CHECKER_TASKS_SVH

// filler symbols random, checked fields explicit
function automatic osPkg::trainingSet_t makeTs(input logic [7:0] start, input logic [7:0] id,
                                               input logic [7:0] link, input logic [7:0] lane,
                                               input logic [7:0] rate, input logic [7:0] sym6);
    osPkg::trainingSet_t ts;
    ts.startSym  = start;
    ts.linkNum   = link;
    ts.laneNum   = lane;
    ts.sym3      = 8'($urandom);
    ts.rateId    = rate;
    ts.sym5      = 8'($urandom);
    ts.symbol6   = sym6;
    ts.sym9to7   = 24'($urandom);
    ts.idSym     = id;
    ts.sym15to11 = {8'($urandom), 32'($urandom)};
    return ts;
endfunction

function automatic osPkg::trainingSet_t ts1(input logic [7:0] link, input logic [7:0] lane,
                                            input logic [7:0] rate);
    return makeTs(osPkg::comSym, osPkg::ts1Id, link, lane, rate, 8'h00);
endfunction

function automatic osPkg::trainingSet_t ts2(input logic [7:0] link, input logic [7:0] lane,
                                            input logic [7:0] rate, input logic [7:0] sym6);
    return makeTs(osPkg::comSym, osPkg::ts2Id, link, lane, rate, sym6);
endfunction

function automatic logic [7:0] makeRate(input logic speed, input logic upcfg);
    osPkg::rateId_t r;
    r.speedChange = speed;
    r.upperBits   = 4'b0000;
    r.upconfigure = upcfg;
    r.lowerBits   = 2'b11;  // supported data rates
    return r;
endfunction

task automatic checkBit(input string name, input logic got, input logic expected);
    if (got !== expected)
    begin
        errorCount++;
        $display("error %s: got 0x%0h expected 0x%0h at %0t", name, got, expected, $time);
    end
endtask

task automatic checkRate(input logic [7:0] got, input logic [7:0] expected);
    if (got !== expected)
    begin
        errorCount++;
        $display("error rateId: got 0x%02h expected 0x%02h at %0t", got, expected, $time);
    end
endtask

task automatic checkLink(input logic [7:0] got, input logic [7:0] expected);
    if (got !== expected)
    begin
        errorCount++;
        $display("error linkNumberOut: got 0x%02h expected 0x%02h at %0t", got, expected, $time);
    end
endtask

// one cycle per set, results checked 1 ns after the edge that takes it
task automatic driveSet(input osPkg::ltssmSubstate_t st, input logic v,
                        input osPkg::trainingSet_t ts, input logic counts);
    substate   = st;
    valid      = v;
    orderedSet = ts;
    if (st != prevSubstate)
    begin
        expKeep = 1'b0;   // new substate, back to hunting
        expIdle = 1'b0;
    end
    if (v)
    begin
        expKeep  = counts;
        expIdle  = counts && (st == osPkg::recoveryRcvrCfg) && !ts.rateId.speedChange;
        expRate  = ts.rateId;
        expLink  = ts.linkNum;
        expUpcfg = ts.rateId.upconfigure;
    end
    prevSubstate = st;
    @(posedge clk);
    #1;
    checkBit("countUp", countUp, v && counts);
    checkBit("keepCount", keepCount, expKeep);
    checkBit("rcvrCfgToIdle", rcvrCfgToIdle, expIdle);
    checkRate(rateId, expRate);
    checkLink(linkNumberOut, expLink);
    checkBit("upconfigureCapability", upconfigureCapability, expUpcfg);
endtask

task automatic sendSet(input osPkg::ltssmSubstate_t st, input osPkg::trainingSet_t ts,
                       input logic counts);
    driveSet(st, 1'b1, ts, counts);
endtask

// junk set with valid low, must be ignored
task automatic gap(input osPkg::ltssmSubstate_t st);
    driveSet(st, 1'b0, ts1(8'h33, 8'h44, 8'hFF), 1'b0);
endtask

task automatic finishTest(input string name);
    testCount++;
    if (errorCount != testStartErrors)
        failedTests++;
    $display("%s: %0d errors", name, errorCount - testStartErrors);
    testStartErrors = errorCount;
endtask

task automatic pollingTest();
    logic [7:0] r;
    r = makeRate(1'b0, 1'b0);
    sendSet(osPkg::pollingActive, ts1(pad, pad, r), 1'b1);
    sendSet(osPkg::pollingActive, ts2(pad, pad, r, 8'h00), 1'b1);
    sendSet(osPkg::pollingActive, makeTs(osPkg::gen3Ts1Start, osPkg::ts1Id, pad, pad, r, 8'h00),
            1'b1);
    sendSet(osPkg::pollingActive, ts1(pad, ourLane, r), 1'b0);  // lane number too early
    sendSet(osPkg::pollingConfiguration, ts2(pad, pad, r, 8'h00), 1'b1);
    sendSet(osPkg::pollingConfiguration, makeTs(osPkg::gen3Ts2Start, osPkg::ts2Id, pad, pad, r,
            8'h00), 1'b1);
    sendSet(osPkg::pollingConfiguration, ts1(pad, pad, r), 1'b0);
    finishTest("polling");
endtask

task automatic linkwidthTest();
    logic [7:0] r;
    r = makeRate(1'b0, 1'b0);
    sendSet(osPkg::configLinkwidthStart, ts1(ourLink, pad, r), 1'b1);
    sendSet(osPkg::configLinkwidthStart, ts1(ourLink, pad, r), 1'b1);
    sendSet(osPkg::configLinkwidthStart, ts1(8'h07, pad, r), 1'b0);  // link number moved
    sendSet(osPkg::configLinkwidthStart, ts1(8'h07, pad, r), 1'b1);
    sendSet(osPkg::configLinkwidthStart, ts1(pad, pad, r), 1'b0);
    sendSet(osPkg::configLinkwidthAccept, ts1(ourLink, ourLane, r), 1'b1);
    sendSet(osPkg::configLinkwidthAccept, ts1(ourLink, ourLane, r), 1'b1);
    sendSet(osPkg::configLinkwidthAccept, ts1(8'h07, ourLane, r), 1'b0);
    sendSet(osPkg::configLanenumWait, ts2(ourLink, ourLane, r, 8'h00), 1'b1);
    sendSet(osPkg::configLanenumWait, ts2(ourLink, ourLane, r, 8'h00), 1'b1);
    sendSet(osPkg::configLanenumWait, ts2(8'h07, ourLane, r, 8'h00), 1'b0);
    finishTest("linkwidth");
endtask

task automatic completeTest();
    sendSet(osPkg::configLanenumAccept, ts2(ourLink, ourLane, makeRate(1'b0, 1'b1), 8'h00), 1'b1);
    sendSet(osPkg::configLanenumAccept, ts2(ourLink, ourLane, makeRate(1'b0, 1'b1), 8'h00), 1'b1);
    sendSet(osPkg::configComplete, ts2(ourLink, ourLane, makeRate(1'b0, 1'b1), 8'h00), 1'b1);
    sendSet(osPkg::configComplete, ts2(ourLink, ourLane, makeRate(1'b0, 1'b1), 8'h00), 1'b1);
    sendSet(osPkg::configComplete, ts2(ourLink, ourLane, makeRate(1'b0, 1'b0), 8'h00), 1'b0);
    sendSet(osPkg::configComplete, ts2(ourLink, ourLane, makeRate(1'b0, 1'b0), 8'h00), 1'b1);
    sendSet(osPkg::configComplete, ts1(ourLink, ourLane, makeRate(1'b0, 1'b1)), 1'b0);
    finishTest("complete");
endtask

task automatic rcvrCfgTest();
    logic [7:0] idle;
    logic [7:0] speed;
    idle  = makeRate(1'b0, 1'b0);
    speed = makeRate(1'b1, 1'b0);
    sendSet(osPkg::recoveryRcvrCfg, ts2(ourLink, ourLane, idle, 8'h10), 1'b1);
    sendSet(osPkg::recoveryRcvrCfg, ts2(ourLink, ourLane, idle, 8'h10), 1'b1);
    sendSet(osPkg::recoveryRcvrCfg, ts2(ourLink, ourLane, speed, 8'h10), 1'b0);  // mode switch
    sendSet(osPkg::recoveryRcvrCfg, ts2(ourLink, ourLane, speed, 8'h10), 1'b1);
    sendSet(osPkg::recoveryRcvrCfg, ts2(ourLink, ourLane, speed, 8'h10), 1'b1);
    sendSet(osPkg::recoveryRcvrCfg, ts2(ourLink, ourLane, speed, 8'h11), 1'b0);
    sendSet(osPkg::recoveryRcvrCfg, ts2(ourLink, ourLane, speed, 8'h11), 1'b1);
    sendSet(osPkg::recoveryRcvrCfg, ts2(ourLink, ourLane, idle, 8'h11), 1'b0);
    sendSet(osPkg::recoveryRcvrCfg, ts2(ourLink, ourLane, idle, 8'h11), 1'b1);
    finishTest("rcvrCfg");
endtask

task automatic idleLockTest();
    sendSet(osPkg::configIdle, '0, 1'b1);
    sendSet(osPkg::configIdle, '0, 1'b1);
    sendSet(osPkg::configIdle, ts1(ourLink, ourLane, makeRate(1'b0, 1'b0)), 1'b0);
    sendSet(osPkg::configIdle, '0, 1'b1);
    directedSpeedChange = 1'b1;
    sendSet(osPkg::recoveryRcvrLock, ts1(ourLink, ourLane, makeRate(1'b1, 1'b0)), 1'b1);
    sendSet(osPkg::recoveryRcvrLock, ts1(ourLink, ourLane, makeRate(1'b1, 1'b0)), 1'b1);
    sendSet(osPkg::recoveryRcvrLock, ts1(ourLink, ourLane, makeRate(1'b0, 1'b0)), 1'b0);
    sendSet(osPkg::recoveryRcvrLock, ts2(ourLink, ourLane, makeRate(1'b1, 1'b0), 8'h00), 1'b1);
    directedSpeedChange = 1'b0;
    finishTest("idleLock");
endtask

task automatic gapTest();
    sendSet(osPkg::configComplete, ts2(ourLink, ourLane, makeRate(1'b0, 1'b1), 8'h00), 1'b1);
    gap(osPkg::configComplete);
    gap(osPkg::configComplete);
    sendSet(osPkg::configComplete, ts2(ourLink, ourLane, makeRate(1'b0, 1'b1), 8'h00), 1'b1);
    gap(osPkg::configLanenumAccept);  // substate change alone ends the run
    sendSet(osPkg::configLanenumAccept, ts2(ourLink, ourLane, makeRate(1'b0, 1'b1), 8'h00), 1'b1);
    sendSet(osPkg::configComplete, ts2(ourLink, ourLane, makeRate(1'b0, 1'b0), 8'h00), 1'b1);
    sendSet(osPkg::configComplete, ts2(ourLink, ourLane, makeRate(1'b0, 1'b0), 8'h00), 1'b1);
    sendSet(osPkg::l0, ts2(ourLink, ourLane, makeRate(1'b0, 1'b0), 8'h00), 1'b0);
    gap(osPkg::l0);
    finishTest("gaps");
endtask

`endif

/* test/osCheckerTb.sv */
`timescale 1ns/1ps
`default_nettype none

module osCheckerTb;

    localparam int clkPeriod   = 10;
    localparam int resetCycles = 3;
    localparam int setBudget   = 80;    // upper bound on sets driven by all tests
    localparam int watchdogNs  = (setBudget + resetCycles + 10) * clkPeriod;

    localparam logic [7:0] pad     = osPkg::padSym;
    localparam logic [7:0] ourLink = 8'h05;
    localparam logic [7:0] ourLane = 8'h02;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  valid;
    osPkg::trainingSet_t   orderedSet;
    osPkg::ltssmSubstate_t substate;
    logic [7:0]            linkNumber;
    logic [7:0]            laneNumber;
    logic                  directedSpeedChange;
    logic                  countUp;
    logic                  keepCount;
    logic                  rcvrCfgToIdle;
    logic [7:0]            rateId;
    logic [7:0]            linkNumberOut;
    logic                  upconfigureCapability;

    int                    errorCount;
    int                    testCount;
    int                    failedTests;
    int                    testStartErrors;

    // reference model state
    osPkg::ltssmSubstate_t prevSubstate;
    logic                  expKeep;
    logic                  expIdle;
    logic [7:0]            expRate;
    logic [7:0]            expLink;
    logic                  expUpcfg;

    osChecker #(
        .isUpstream(1'b1)
    ) dut0 (
        .clk                   (clk),
        .reset                 (reset),
        .valid                 (valid),
        .orderedSet            (orderedSet),
        .substate              (substate),
        .linkNumber            (linkNumber),
        .laneNumber            (laneNumber),
        .directedSpeedChange   (directedSpeedChange),
        .countUp               (countUp),
        .keepCount             (keepCount),
        .rcvrCfgToIdle         (rcvrCfgToIdle),
        .rateId                (rateId),
        .linkNumberOut         (linkNumberOut),
        .upconfigureCapability (upconfigureCapability)
    );

    `include "osCheckerTasks.svh"

    always #(clkPeriod / 2) clk = ~clk;

    initial
    begin
        void'($urandom(32'h866a_8639));
        reset               = 1'b0;
        valid               = 1'b0;
        orderedSet          = '0;
        substate            = osPkg::detectQuiet;
        linkNumber          = ourLink;
        laneNumber          = ourLane;
        directedSpeedChange = 1'b0;
        errorCount          = 0;
        testCount           = 0;
        failedTests         = 0;
        testStartErrors     = 0;
        prevSubstate        = osPkg::detectQuiet;  // matches the tracker after reset
        expKeep             = 1'b0;
        expIdle             = 1'b0;
        expRate             = 8'h00;
        expLink             = 8'h00;
        expUpcfg            = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        reset = 1'b1;

        pollingTest();
        linkwidthTest();
        completeTest();
        rcvrCfgTest();
        idleLockTest();
        gapTest();

        $display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
        if (errorCount == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        #(watchdogNs);
        $display("timeout: tests still running after %0d ns", watchdogNs);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
